// ==== hw/spi_pkg.sv ====
package spi_pkg;

  // ------------------------------
  // Data types
  // ------------------------------

  // One byte on the SPI wire, MSB first
  typedef logic [7:0] byte_t;

  // ------------------------------
  // Command byte layout
  // ------------------------------

  // Register address in bits 6:0 of the command byte
  localparam int REG_ADDR_BITS = 7;

  // Set for a write, clear for a read
  localparam int CMD_WRITE_BIT = 7;

  // ------------------------------
  // Register bank and filler
  // ------------------------------

  // One byte per address
  localparam int REG_COUNT = 1 << REG_ADDR_BITS;

  // Sent in any slot that finds nothing queued
  localparam byte_t DEFAULT_HEADER = 8'hA7;

endpackage

// ==== hw/stream_fifo.sv ====
`timescale 1ns/10ps
module stream_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  // Full or empty requests are dropped here
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_BITS'(DEPTH));

  // Head word is visible while not empty
  assign data_o = mem[rd_ptr];

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

// ==== hw/spi_layer.sv ====
`timescale 1ns/10ps
module spi_layer #(
  parameter spi_pkg::byte_t HEADER = spi_pkg::DEFAULT_HEADER,
  parameter int             DEPTH  = 16
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           sck_i,
  input  logic           ssel_i,
  input  logic           mosi_i,
  output logic           miso_o,
  output logic           cycle_o,
  output logic           fetch_o,
  input  logic           tx_valid_i,
  input  spi_pkg::byte_t tx_data_i,
  output logic           rx_empty_o,
  input  logic           rx_ack_i,
  output spi_pkg::byte_t rx_data_o,
  output logic           overflow_o,
  output logic           underrun_o
);

  import spi_pkg::*;

  // Index 0 and 1 form the synchronizer, index 2 is the previous value
  logic [2:0] sck_q;
  logic [2:0] ssel_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       ssel_fall;
  logic [2:0] bit_cnt;
  logic       rx_push;
  logic       rx_full;
  logic       tx_empty;
  logic       tx_filler;
  byte_t      rx_shift;
  byte_t      rx_byte;
  byte_t      tx_shift;
  byte_t      tx_head;

  // ------------------------------
  // Pin synchronizers
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      sck_q  <= '0;
      ssel_q <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck_i};
      ssel_q <= {ssel_q[1:0], ssel_i};
      mosi_q <= {mosi_q[0], mosi_i};
    end
  end

  assign sck_rise  = sck_q[1] && !sck_q[2];
  assign sck_fall  = !sck_q[1] && sck_q[2];
  assign ssel_fall = ssel_q[2] && !ssel_q[1];

  // SSEL is active low
  assign cycle_o = !ssel_q[1];

  // ------------------------------
  // Byte slots
  // ------------------------------

  // Eighth rising edge closes a slot
  assign rx_push = cycle_o && sck_rise && (bit_cnt == 3'd7);
  assign rx_byte = {rx_shift[6:0], mosi_q[1]};

  // Next transmit byte at SSEL fall and at every slot end
  assign fetch_o = ssel_fall || rx_push;

  // Output only while selected
  assign miso_o = cycle_o && tx_shift[7];

  always_ff @(posedge clock) begin
    if (reset) begin
      bit_cnt    <= '0;
      tx_filler  <= 1'b0;
      tx_shift   <= '0;
      overflow_o <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      overflow_o <= rx_push && rx_full;
      underrun_o <= 1'b0;
      if (!cycle_o) begin
        bit_cnt   <= '0;
        tx_filler <= 1'b0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Filler counts only once the master clocks it out,
        // so the slot fetched after the last byte stays silent
        if (bit_cnt == 3'd0 && tx_filler) begin
          underrun_o <= 1'b1;
          tx_filler  <= 1'b0;
        end
      end
      if (fetch_o) begin
        tx_filler <= tx_empty;
        tx_shift  <= tx_empty ? HEADER : tx_head;
      end else if (cycle_o && sck_fall && bit_cnt != 3'd0) begin
        // Falling edge after the last bit keeps the new MSB
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  // MOSI sampled on rising edges
  always_ff @(posedge clock) begin
    if (cycle_o && sck_rise) begin
      rx_shift <= rx_byte;
    end
  end

  // ------------------------------
  // Receive and transmit FIFOs
  // ------------------------------

  stream_fifo #(
    .WIDTH($bits(byte_t)),
    .DEPTH(DEPTH)
  ) u_rx_fifo (
    .clock  (clock),
    .reset  (reset),
    .push_i (rx_push),
    .data_i (rx_byte),
    .pop_i  (rx_ack_i),
    .data_o (rx_data_o),
    .empty_o(rx_empty_o),
    .full_o (rx_full)
  );

  // Pop while empty is ignored, the slot gets HEADER instead
  stream_fifo #(
    .WIDTH($bits(byte_t)),
    .DEPTH(DEPTH)
  ) u_tx_fifo (
    .clock  (clock),
    .reset  (reset),
    .push_i (tx_valid_i),
    .data_i (tx_data_i),
    .pop_i  (fetch_o),
    .data_o (tx_head),
    .empty_o(tx_empty),
    .full_o ()
  );

endmodule

// ==== hw/spi_target.sv ====
`timescale 1ns/10ps
module spi_target #(
  parameter spi_pkg::byte_t HEADER = spi_pkg::DEFAULT_HEADER,
  parameter int             DEPTH  = 16
) (
  input  logic           clock,
  input  logic           reset,
  input  logic [6:0]     status_i,
  input  logic           sck_i,
  input  logic           ssel_i,
  input  logic           mosi_i,
  output logic           miso_o,
  output logic           overflow_o,
  output logic           underrun_o,
  output logic           rx_valid_o,
  input  logic           rx_ack_i,
  output spi_pkg::byte_t rx_data_o,
  input  logic           resp_push_i,
  input  spi_pkg::byte_t resp_data_i
);

  import spi_pkg::*;

  typedef enum logic [1:0] {
    ST_FILL,
    ST_IDLE,
    ST_XFER
  } state_t;

  state_t state;
  logic   cycle;
  logic   rx_empty;
  logic   tx_valid;
  byte_t  tx_data;

  // Status goes in once per transfer, responses otherwise
  assign tx_valid = (state == ST_FILL) || resp_push_i;
  assign tx_data  = (state == ST_FILL) ? {1'b0, status_i} : resp_data_i;

  assign rx_valid_o = !rx_empty;

  // ------------------------------
  // Transaction FSM
  // ------------------------------

  // Status is sampled once the previous transfer has drained
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_FILL;
    end else begin
      case (state)
        // One push primes slot 0
        ST_FILL: state <= ST_IDLE;
        // Wait for the first received byte
        ST_IDLE: if (cycle && !rx_empty) state <= ST_XFER;
        // SSEL released and every byte consumed
        ST_XFER: if (!cycle && rx_empty) state <= ST_FILL;
        default: state <= ST_FILL;
      endcase
    end
  end

  spi_layer #(
    .HEADER(HEADER),
    .DEPTH (DEPTH)
  ) u_spi_layer (
    .clock     (clock),
    .reset     (reset),
    .sck_i     (sck_i),
    .ssel_i    (ssel_i),
    .mosi_i    (mosi_i),
    .miso_o    (miso_o),
    .cycle_o   (cycle),
    .fetch_o   (),
    .tx_valid_i(tx_valid),
    .tx_data_i (tx_data),
    .rx_empty_o(rx_empty),
    .rx_ack_i  (rx_ack_i),
    .rx_data_o (rx_data_o),
    .overflow_o(overflow_o),
    .underrun_o(underrun_o)
  );

endmodule

// ==== hw/reg_command.sv ====
`timescale 1ns/10ps
module reg_command (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             rx_valid_i,
  output logic                             rx_ack_o,
  input  spi_pkg::byte_t                   rx_data_i,
  output logic                             spi_req_o,
  output logic                             spi_we_o,
  output logic [spi_pkg::REG_ADDR_BITS-1:0] spi_addr_o,
  output spi_pkg::byte_t                   spi_wdata_o,
  input  logic                             spi_gnt_i,
  input  spi_pkg::byte_t                   spi_rdata_i,
  output logic                             resp_push_o,
  output spi_pkg::byte_t                   resp_data_o
);

  import spi_pkg::*;

  typedef enum logic [1:0] {
    ST_CMD,
    ST_WDATA,
    ST_BANK,
    ST_DUMMY
  } state_t;

  state_t state;
  logic   dummy_last;

  // Bytes wait in the receive FIFO while the bank is busy
  assign rx_ack_o = rx_valid_i && (state != ST_BANK);

  // Bank data lands one cycle after the read grant
  assign resp_data_o = spi_rdata_i;

  // ------------------------------
  // Command decode
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= ST_CMD;
      dummy_last  <= 1'b0;
      spi_req_o   <= 1'b0;
      spi_we_o    <= 1'b0;
      resp_push_o <= 1'b0;
    end else begin
      resp_push_o <= spi_req_o && spi_gnt_i && !spi_we_o;
      case (state)
        ST_CMD: if (rx_ack_o) begin
          spi_we_o <= rx_data_i[CMD_WRITE_BIT];
          if (rx_data_i[CMD_WRITE_BIT]) begin
            state <= ST_WDATA;
          end else begin
            // Read goes out at once, ahead of the dummies
            spi_req_o <= 1'b1;
            state     <= ST_BANK;
          end
        end
        ST_WDATA: if (rx_ack_o) begin
          spi_req_o <= 1'b1;
          state     <= ST_BANK;
        end
        // Request held until granted
        ST_BANK: if (spi_gnt_i) begin
          spi_req_o  <= 1'b0;
          dummy_last <= 1'b0;
          state      <= spi_we_o ? ST_CMD : ST_DUMMY;
        end
        // Two dummy bytes dropped
        ST_DUMMY: if (rx_ack_o) begin
          dummy_last <= 1'b1;
          if (dummy_last) state <= ST_CMD;
        end
        default: state <= ST_CMD;
      endcase
    end
  end

  // Address and data of the pending request
  always_ff @(posedge clock) begin
    if (state == ST_CMD && rx_ack_o) begin
      spi_addr_o <= rx_data_i[REG_ADDR_BITS-1:0];
    end
    if (state == ST_WDATA && rx_ack_o) begin
      spi_wdata_o <= rx_data_i;
    end
  end

endmodule

// ==== hw/shared_reg_bank.sv ====
`timescale 1ns/10ps
module shared_reg_bank (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             spi_req_i,
  input  logic                             spi_we_i,
  input  logic [spi_pkg::REG_ADDR_BITS-1:0] spi_addr_i,
  input  spi_pkg::byte_t                   spi_wdata_i,
  output logic                             spi_gnt_o,
  output spi_pkg::byte_t                   spi_rdata_o,
  input  logic                             host_req_i,
  input  logic                             host_we_i,
  input  logic [spi_pkg::REG_ADDR_BITS-1:0] host_addr_i,
  input  spi_pkg::byte_t                   host_wdata_i,
  output logic                             host_gnt_o,
  output spi_pkg::byte_t                   host_rdata_o,
  output logic                             host_rvalid_o
);

  import spi_pkg::*;

  byte_t regs [REG_COUNT];
  byte_t rd_q;

  // ------------------------------
  // Arbiter
  // ------------------------------

  // SPI side always wins, host retries next cycle
  assign spi_gnt_o  = spi_req_i;
  assign host_gnt_o = host_req_i && !spi_req_i;

  // One grant per cycle, so both ports share the read register
  assign spi_rdata_o  = rd_q;
  assign host_rdata_o = rd_q;

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      host_rvalid_o <= 1'b0;
    end else begin
      // Read strobe for host reads only
      host_rvalid_o <= host_gnt_o && !host_we_i;
      if (spi_gnt_o && spi_we_i) begin
        regs[spi_addr_i] <= spi_wdata_i;
      end else if (host_gnt_o && host_we_i) begin
        regs[host_addr_i] <= host_wdata_i;
      end
    end
  end

  // Read data of whichever port holds the grant
  always_ff @(posedge clock) begin
    if (spi_gnt_o) begin
      rd_q <= regs[spi_addr_i];
    end else if (host_gnt_o) begin
      rd_q <= regs[host_addr_i];
    end
  end

endmodule

// ==== hw/spi_regs_top.sv ====
`timescale 1ns/10ps
module spi_regs_top #(
  parameter spi_pkg::byte_t HEADER = spi_pkg::DEFAULT_HEADER,
  parameter int             DEPTH  = 16
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [6:0]                       status_i,
  input  logic                             sck_i,
  input  logic                             ssel_i,
  input  logic                             mosi_i,
  output logic                             miso_o,
  output logic                             overflow_o,
  output logic                             underrun_o,
  input  logic                             host_req_i,
  input  logic                             host_we_i,
  input  logic [spi_pkg::REG_ADDR_BITS-1:0] host_addr_i,
  input  spi_pkg::byte_t                   host_wdata_i,
  output logic                             host_gnt_o,
  output spi_pkg::byte_t                   host_rdata_o,
  output logic                             host_rvalid_o
);

  import spi_pkg::*;

  // SPI target to command decoder
  logic                     rx_valid;
  logic                     rx_ack;
  byte_t                    rx_data;
  logic                     resp_push;
  byte_t                    resp_data;

  // Command decoder to bank
  logic                     spi_req;
  logic                     spi_we;
  logic [REG_ADDR_BITS-1:0] spi_addr;
  byte_t                    spi_wdata;
  logic                     spi_gnt;
  byte_t                    spi_rdata;

  spi_target #(
    .HEADER(HEADER),
    .DEPTH (DEPTH)
  ) u_spi_target (
    .clock      (clock),
    .reset      (reset),
    .status_i   (status_i),
    .sck_i      (sck_i),
    .ssel_i     (ssel_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .overflow_o (overflow_o),
    .underrun_o (underrun_o),
    .rx_valid_o (rx_valid),
    .rx_ack_i   (rx_ack),
    .rx_data_o  (rx_data),
    .resp_push_i(resp_push),
    .resp_data_i(resp_data)
  );

  reg_command u_reg_command (
    .clock      (clock),
    .reset      (reset),
    .rx_valid_i (rx_valid),
    .rx_ack_o   (rx_ack),
    .rx_data_i  (rx_data),
    .spi_req_o  (spi_req),
    .spi_we_o   (spi_we),
    .spi_addr_o (spi_addr),
    .spi_wdata_o(spi_wdata),
    .spi_gnt_i  (spi_gnt),
    .spi_rdata_i(spi_rdata),
    .resp_push_o(resp_push),
    .resp_data_o(resp_data)
  );

  shared_reg_bank u_shared_reg_bank (
    .clock        (clock),
    .reset        (reset),
    .spi_req_i    (spi_req),
    .spi_we_i     (spi_we),
    .spi_addr_i   (spi_addr),
    .spi_wdata_i  (spi_wdata),
    .spi_gnt_o    (spi_gnt),
    .spi_rdata_o  (spi_rdata),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rdata_o (host_rdata_o),
    .host_rvalid_o(host_rvalid_o)
  );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clock_o,
  output logic reset_o
);

  // Free-running clock
  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  // Reset held for RESET_CYCLES rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

// ==== tests/spi_regs_tb.sv ====
`timescale 1ns/10ps
module spi_regs_tb;

  import spi_pkg::*;

  // ------------------------------
  // Constants
  // ------------------------------

  localparam byte_t HEADER   = 8'hA7;
  localparam int    DEPTH    = 16;
  // Clock cycles per SCK half period
  localparam int    SCK_HALF = 8;
  // Quiet time after SSEL release covers the drain and the status push
  localparam int    IDLE_GAP = 24;
  // Up to 30 transfers of about 420 cycles plus host traffic stay near 13000 cycles
  localparam int    TIMEOUT_CYCLES = 20000;

  logic                     clock;
  logic                     reset;
  logic [6:0]               status;
  logic                     sck;
  logic                     ssel;
  logic                     mosi;
  logic                     miso;
  logic                     overflow;
  logic                     underrun;
  logic                     host_req;
  logic                     host_we;
  logic [REG_ADDR_BITS-1:0] host_addr;
  byte_t                    host_wdata;
  logic                     host_gnt;
  byte_t                    host_rdata;
  logic                     host_rvalid;

  // Reference model of the bank and of the status byte
  byte_t       model_regs [REG_COUNT];
  byte_t       expected_status;
  // Bytes of the current transfer
  byte_t       mosi_buf [3];
  byte_t       miso_buf [3];
  logic [31:0] lfsr_state;
  int          cur_slot;
  int          underrun_count;
  int          underrun_slot;
  int          overflow_count;
  int          xfer_underruns;
  logic        arb_watch;
  int          host_grants;
  int          host_stalls;
  int          check_count;
  int          error_count;
  int          cycle_count;

  tb_clock #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(4)
  ) u_tb_clock (
    .clock_o(clock),
    .reset_o(reset)
  );

  spi_regs_top #(
    .HEADER(HEADER),
    .DEPTH (DEPTH)
  ) u_spi_regs_top (
    .clock        (clock),
    .reset        (reset),
    .status_i     (status),
    .sck_i        (sck),
    .ssel_i       (ssel),
    .mosi_i       (mosi),
    .miso_o       (miso),
    .overflow_o   (overflow),
    .underrun_o   (underrun),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rdata_o (host_rdata),
    .host_rvalid_o(host_rvalid)
  );

  // Count flag pulses and note the slot of each underrun
  always @(posedge clock) begin
    if (!reset) begin
      if (underrun) begin
        underrun_count++;
        underrun_slot = cur_slot;
      end
      if (overflow) begin
        overflow_count++;
      end
      // Host request outcome while the arbitration window is open
      if (arb_watch && host_req) begin
        if (host_gnt) begin
          host_grants++;
        end else begin
          host_stalls++;
        end
      end
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
      $display("Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("[%0t] %s: %0d errors", $time, name, error_count - start_errors);
  endtask

  // ------------------------------
  // SPI master in mode 0
  // ------------------------------

  // Shifts mosi_buf[0..n-1] out and fills miso_buf
  task automatic spi_transfer(input int n_bytes);
    byte_t rx;
    int    start_underruns;
    start_underruns = underrun_count;
    @(negedge clock);
    ssel = 1'b0;
    for (int i = 0; i < n_bytes; i++) begin
      cur_slot = i;
      rx = '0;
      for (int b = 7; b >= 0; b--) begin
        // MOSI changes with the falling edge
        // The first low phase also covers the SSEL setup
        sck  = 1'b0;
        mosi = mosi_buf[i][b];
        repeat (SCK_HALF) @(negedge clock);
        // MISO taken at the rising edge
        rx  = {rx[6:0], miso};
        sck = 1'b1;
        repeat (SCK_HALF) @(negedge clock);
      end
      miso_buf[i] = rx;
    end
    sck = 1'b0;
    repeat (SCK_HALF) @(negedge clock);
    ssel = 1'b1;
    mosi = 1'b0;
    repeat (IDLE_GAP) @(negedge clock);
    // Status is loaded between transfers, so the next one sends this value
    expected_status = {1'b0, status};
    xfer_underruns  = underrun_count - start_underruns;
  endtask

  // Write sends a command with bit 7 set and a data byte
  // MISO carries status and HEADER
  task automatic spi_write(input logic [6:0] addr, input byte_t data);
    byte_t status_exp;
    status_exp  = expected_status;
    mosi_buf[0] = {1'b1, addr};
    mosi_buf[1] = data;
    spi_transfer(2);
    check_value("SPI write status byte", miso_buf[0], status_exp);
    check_value("SPI write slot 1 filler", miso_buf[1], HEADER);
    model_regs[addr] = data;
  endtask

  // Read sends a command with bit 7 clear and two dummies
  // MISO carries status, HEADER and the data
  task automatic spi_read(input logic [6:0] addr);
    byte_t status_exp;
    status_exp  = expected_status;
    mosi_buf[0] = {1'b0, addr};
    mosi_buf[1] = 8'h00;
    mosi_buf[2] = 8'h00;
    spi_transfer(3);
    check_value("SPI read status byte", miso_buf[0], status_exp);
    check_value("SPI read slot 1 filler", miso_buf[1], HEADER);
    check_value("SPI read data", miso_buf[2], model_regs[addr]);
  endtask

  // ------------------------------
  // Host port
  // ------------------------------

  task automatic host_access(input logic we, input logic [6:0] addr,
                             input byte_t wdata, output byte_t rdata);
    @(negedge clock);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    // Grant seen just before the edge that acts on it
    @(posedge clock);
    while (!host_gnt) @(posedge clock);
    @(negedge clock);
    host_req = 1'b0;
    host_we  = 1'b0;
    rdata    = host_rdata;
    if (!we) begin
      check_value("host read valid", host_rvalid, 1);
    end
  endtask

  task automatic host_write(input logic [6:0] addr, input byte_t data);
    byte_t unused;
    host_access(1'b1, addr, data, unused);
    model_regs[addr] = data;
  endtask

  task automatic host_read(input logic [6:0] addr);
    byte_t rd;
    host_access(1'b0, addr, 8'h00, rd);
    check_value("host read data", rd, model_regs[addr]);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  // Each transfer sends the status that was set before the previous one ended
  task automatic status_byte_test();
    logic [6:0] values [4];
    int         start;
    start     = error_count;
    values[0] = 7'h5a;
    values[1] = 7'h7f;
    values[2] = 7'h00;
    values[3] = 7'h13;
    for (int i = 0; i < 4; i++) begin
      status = values[i];
      spi_write(7'(random_bits(7)), 8'(random_bits(8)));
    end
    spi_write(7'(random_bits(7)), 8'(random_bits(8)));
    report_test("status byte", start);
  endtask

  task automatic spi_write_host_read_test();
    logic [6:0] addr;
    int         start;
    start = error_count;
    addr  = 7'(random_bits(7));
    spi_write(addr, 8'(random_bits(8)));
    host_read(addr);
    report_test("SPI write, host read", start);
  endtask

  task automatic host_write_spi_read_test();
    logic [6:0] addr;
    int         start;
    start = error_count;
    addr  = 7'(random_bits(7));
    host_write(addr, 8'(random_bits(8)));
    spi_read(addr);
    report_test("host write, SPI read", start);
  endtask

  // Host write held across an SPI write that takes the bank for one cycle
  task automatic arbitration_test();
    logic [6:0] addr_a;
    logic [6:0] addr_b;
    byte_t      data_a;
    byte_t      data_b;
    int         start;
    start       = error_count;
    addr_a      = 7'(random_bits(7));
    addr_b      = addr_a ^ 7'h40;
    data_a      = 8'(random_bits(8));
    data_b      = 8'(random_bits(8));
    host_stalls = 0;
    host_grants = 0;
    @(negedge clock);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr_a;
    host_wdata = data_a;
    arb_watch  = 1'b1;
    spi_write(addr_b, data_b);
    arb_watch = 1'b0;
    host_req  = 1'b0;
    host_we   = 1'b0;
    model_regs[addr_a] = data_a;
    check_value("host stall cycles", host_stalls, 1);
    check_value("host granted", host_grants > 0, 1);
    host_read(addr_a);
    host_read(addr_b);
    report_test("arbitration", start);
  endtask

  // One underrun per transfer and always in slot 1
  task automatic error_flags_test();
    logic [6:0] addr;
    int         start;
    start = error_count;
    addr  = 7'(random_bits(7));
    spi_write(addr, 8'(random_bits(8)));
    check_value("underruns in write transfer", xfer_underruns, 1);
    check_value("underrun slot in write transfer", underrun_slot, 1);
    spi_read(addr);
    check_value("underruns in read transfer", xfer_underruns, 1);
    check_value("underrun slot in read transfer", underrun_slot, 1);
    check_value("overflow pulses", overflow_count, 0);
    report_test("error flags", start);
  endtask

  task automatic random_traffic_test();
    logic [1:0] op;
    logic [6:0] addr;
    byte_t      data;
    int         start;
    start = error_count;
    for (int i = 0; i < 20; i++) begin
      op   = 2'(random_bits(2));
      addr = 7'(random_bits(7));
      data = 8'(random_bits(8));
      case (op)
        2'd0: spi_write(addr, data);
        2'd1: spi_read(addr);
        2'd2: host_write(addr, data);
        default: host_read(addr);
      endcase
    end
    report_test("random traffic", start);
  endtask

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    status         = 7'h21;
    sck            = 1'b0;
    ssel           = 1'b1;
    mosi           = 1'b0;
    host_req       = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    lfsr_state     = 32'h42c9f6d0;
    cur_slot       = 0;
    underrun_count = 0;
    underrun_slot  = -1;
    overflow_count = 0;
    xfer_underruns = 0;
    arb_watch      = 1'b0;
    host_grants    = 0;
    host_stalls    = 0;
    check_count    = 0;
    error_count    = 0;
    // Bank is cleared by reset
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = 8'h00;
    end
    @(negedge clock);
    while (reset) @(negedge clock);
    // First status push happens right after reset
    expected_status = {1'b0, status};
    repeat (4) @(negedge clock);
    status_byte_test();
    spi_write_host_read_test();
    host_write_spi_read_test();
    arbitration_test();
    error_flags_test();
    random_traffic_test();
    $display("Checks: %0d, errors: %0d, underruns: %0d, overflows: %0d",
             check_count, error_count, underrun_count, overflow_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hw/spi_pkg.sv
hw/stream_fifo.sv
hw/spi_layer.sv
hw/spi_target.sv
hw/reg_command.sv
hw/shared_reg_bank.sv
hw/spi_regs_top.sv
tests/tb_clock.sv
tests/spi_regs_tb.sv

// ==== Bender.yml ====
package:
  name: spi_regs

sources:
  - hw/spi_pkg.sv
  - hw/stream_fifo.sv
  - hw/spi_layer.sv
  - hw/spi_target.sv
  - hw/reg_command.sv
  - hw/shared_reg_bank.sv
  - hw/spi_regs_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/spi_regs_tb.sv
